/* sifhGeomPkg.sv */
package sifhGeomPkg;

    localparam int stampBits = 12;                  // tdc timestamp width
    localparam int binBits = 5;                     // bin index and ram address
    localparam int binNum = 1 << binBits;           // 32 bins per pass
    localparam int countBits = 6;
    localparam int countMax = (1 << countBits) - 1; // saturation value
    localparam int stampsPerFrame = 64;             // stamps taken per pass

    // coarse bin is the top slice of a stamp
    // fine bin is the slice just below it
    localparam int coarseLsb = stampBits - binBits;
    localparam int fineLsb = coarseLsb - binBits;

    localparam int frameCntBits = $clog2(stampsPerFrame) + 1; // must reach 64

    typedef logic [stampBits-1:0] stampT;
    typedef logic [binBits-1:0] binT;
    typedef logic [countBits-1:0] countT;
    typedef logic [frameCntBits-1:0] frameCntT;

endpackage

/* sifhCtrlPkg.sv */
package sifhCtrlPkg;

    typedef enum logic [2:0] {
        clearA,   // zero the ram before the coarse pass
        buildA,   // coarse histogram
        scanA,
        window,   // latch coarse peak as filter
        clearB,
        buildB,   // fine histogram inside the window
        scanB,
        report
    } phaseT;

    typedef enum logic [1:0] {
        idle,
        read,
        waitData, // ram output arrives
        write
    } buildStateT;

    typedef struct packed {
        logic en;
        sifhGeomPkg::binT addr;
        sifhGeomPkg::countT data;
    } ramWrT;

    typedef struct packed {
        logic en;
        sifhGeomPkg::binT addr;
    } ramRdT;

    typedef struct packed {
        sifhGeomPkg::binT bin;
        sifhGeomPkg::countT count;
    } peakT;

endpackage

/* histRam.sv */
module histRam (
    input  logic               clk,
    input  sifhCtrlPkg::ramWrT wr,
    input  sifhCtrlPkg::ramRdT rd,
    output sifhGeomPkg::countT rdData
);

    import sifhGeomPkg::*;

    countT mem [0:binNum-1]; // one count per bin

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr]; // valid the cycle after the request
        end
    end

    // the builder spacing and the phase split keep the two ports on different bins,
    // so a read never has to see a write from the same cycle
    noSameBin: assert property (
        @(posedge clk) !(wr.en && rd.en && (wr.addr == rd.addr))
    )
        else $error("histRam: read and write of bin %0d in one cycle", rd.addr);

endmodule

/* hisBuilder.sv */
module hisBuilder (
    input  logic               clk,
    input  logic               res,
    input  logic               take,
    input  sifhGeomPkg::binT   bin,
    input  sifhGeomPkg::countT rdData,
    output logic               busy,
    output sifhCtrlPkg::ramRdT rd,
    output sifhCtrlPkg::ramWrT wr
);

    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;

    buildStateT state;
    binT        binQ;     // bin under update
    countT      newCount; // count to write back

    // one stamp at a time: read, wait for ram, write
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        state <= read;
                    end
                end
                read: begin
                    state <= waitData;
                end
                waitData: begin
                    state <= write;
                end
                write: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            binQ <= bin;
        end
        if (state == waitData) begin
            if (rdData == countT'(countMax)) begin
                newCount <= rdData; // hold at full scale
            end else begin
                newCount <= rdData + 1'b1;
            end
        end
    end

    assign busy = (state != idle);

    assign rd = '{
        en: (state == read),
        addr: binQ
    };

    assign wr = '{
        en: (state == write),
        addr: binQ,
        data: newCount
    };

    // the controller gates take with tdcReady, which follows busy
    takeWhenIdle: assert property (
        @(posedge clk) disable iff (!res)
        take |-> !busy
    )
        else $error("hisBuilder: take while busy");

    // every write closes a read of the same bin two cycles earlier
    writeAfterRead: assert property (
        @(posedge clk) disable iff (!res)
        wr.en |-> ($past(rd.en, 2) && ($past(rd.addr, 2) == wr.addr))
    )
        else $error("hisBuilder: write to bin %0d without a matching read", wr.addr);

endmodule

/* peakScanner.sv */
module peakScanner (
    input  logic               clk,
    input  logic               res,
    input  logic               scanStart,
    output sifhCtrlPkg::ramRdT rd,
    input  sifhGeomPkg::countT rdData,
    output sifhCtrlPkg::peakT  peak,
    output logic               scanDone
);

    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;

    logic active;  // read sweep running
    binT  addrQ;   // next bin to read
    logic dataVld; // rdData belongs to the sweep
    binT  addrD;   // bin that rdData came from
    peakT best;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            addrQ <= '0;
            dataVld <= 1'b0;
            addrD <= '0;
            scanDone <= 1'b0;
            best <= '0;
        end else begin
            dataVld <= active;
            addrD <= addrQ; // follows the one-cycle ram latency
            scanDone <= dataVld && (addrD == binT'(binNum - 1));

            if (scanStart) begin
                active <= 1'b1;
                addrQ <= '0;
            end else if (active) begin
                addrQ <= addrQ + 1'b1;
                if (addrQ == binT'(binNum - 1)) begin
                    active <= 1'b0;
                end
            end

            if (scanStart) begin
                best <= '0; // bin 0, count 0
            end else if (dataVld && (rdData > best.count)) begin
                best.bin <= addrD; // strictly greater, lowest bin wins ties
                best.count <= rdData;
            end
        end
    end

    assign rd = '{
        en: active,
        addr: addrQ
    };

    assign peak = best;

    // a sweep is binNum reads plus two cycles of pipeline
    scanLength: assert property (
        @(posedge clk) disable iff (!res)
        scanStart |-> ##(binNum + 2) scanDone
    )
        else $error("peakScanner: scanDone late or missing");

endmodule

/* sifhTop.sv */
module sifhTop (
    input  logic               clk,
    input  logic               res,
    input  sifhGeomPkg::stampT stamp,
    input  logic               stampValid,
    output logic               tdcReady,
    output logic               resultValid,
    output sifhGeomPkg::binT   coarseBin,
    output sifhGeomPkg::binT   fineBin,
    output sifhGeomPkg::countT fineCount
);

    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;

    phaseT    phase;
    ramWrT    clrWr;     // clear writes, address doubles as counter
    frameCntT stampCnt;  // stamps taken in this pass
    binT      windowBin; // coarse peak of pass A
    logic     scanStart;

    ramWrT builderWr;
    ramRdT builderRd;
    ramRdT scannerRd;
    ramWrT ramWr;
    ramRdT ramRd;
    countT rdData;
    peakT  peak;
    logic  busy;
    logic  scanDone;

    logic inBuild;
    logic frameFull;
    logic accept;
    logic inWindow;
    logic take;
    binT  takeBin;
    binT  stampCoarse;
    binT  stampFine;

    assign stampCoarse = stamp[coarseLsb +: binBits];
    assign stampFine = stamp[fineLsb +: binBits];

    assign inBuild = (phase == buildA) || (phase == buildB);
    assign frameFull = (stampCnt == frameCntT'(stampsPerFrame));
    assign tdcReady = inBuild && !busy && !frameFull;
    assign accept = stampValid && tdcReady;

    // pass B keeps only stamps inside the coarse window
    assign inWindow = (stampCoarse == windowBin);
    assign take = accept && ((phase == buildA) || inWindow);
    assign takeBin = (phase == buildA) ? stampCoarse : stampFine;

    assign resultValid = (phase == report);

    // ram port owner by phase
    always_comb begin
        ramWr = '0;
        ramRd = '0;
        case (phase)
            clearA, clearB: begin
                ramWr = clrWr;
            end
            buildA, buildB: begin
                ramWr = builderWr;
                ramRd = builderRd;
            end
            scanA, scanB: begin
                ramRd = scannerRd;
            end
            default: begin
                ramWr = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= clearA;
            clrWr <= '0;
            stampCnt <= '0;
            windowBin <= '0;
            scanStart <= 1'b0;
            coarseBin <= '0;
            fineBin <= '0;
            fineCount <= '0;
        end else begin
            scanStart <= 1'b0;
            case (phase)
                clearA, clearB: begin
                    if (clrWr.en && (clrWr.addr == binT'(binNum - 1))) begin
                        clrWr.en <= 1'b0; // last bin written
                        clrWr.addr <= '0;
                        phase <= (phase == clearA) ? buildA : buildB;
                    end else begin
                        clrWr.en <= 1'b1;
                        clrWr.addr <= clrWr.en ? clrWr.addr + 1'b1 : '0;
                    end
                end
                buildA, buildB: begin
                    if (accept) begin
                        stampCnt <= stampCnt + 1'b1; // dropped stamps count too
                    end
                    if (frameFull && !busy) begin
                        stampCnt <= '0;
                        scanStart <= 1'b1;
                        phase <= (phase == buildA) ? scanA : scanB;
                    end
                end
                scanA: begin
                    if (scanDone) begin
                        phase <= window;
                    end
                end
                window: begin
                    windowBin <= peak.bin;
                    phase <= clearB;
                end
                scanB: begin
                    if (scanDone) begin
                        coarseBin <= windowBin; // results held until next report
                        fineBin <= peak.bin;
                        fineCount <= peak.count;
                        phase <= report;
                    end
                end
                report: begin
                    phase <= clearA;
                end
                default: begin
                    phase <= clearA;
                end
            endcase
        end
    end

    histRam histRamI (
        .clk    (clk),
        .wr     (ramWr),
        .rd     (ramRd),
        .rdData (rdData)
    );

    hisBuilder hisBuilderI (
        .clk    (clk),
        .res    (res),
        .take   (take),
        .bin    (takeBin),
        .rdData (rdData),
        .busy   (busy),
        .rd     (builderRd),
        .wr     (builderWr)
    );

    peakScanner peakScannerI (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .rd        (scannerRd),
        .rdData    (rdData),
        .peak      (peak),
        .scanDone  (scanDone)
    );

    // the TDC must hold off while ready is low
    strobeOnReady: assert property (
        @(posedge clk) disable iff (!res)
        stampValid |-> tdcReady
    )
        else $error("sifhTop: stamp strobe while tdcReady low, stamp ignored");

    // read, wait and write of the builder keep the TDC off
    readyDropsOnTake: assert property (
        @(posedge clk) disable iff (!res)
        take |=> !tdcReady [*3]
    )
        else $error("sifhTop: tdcReady back before the builder finished");

    // scanner ends only while a scan phase waits for it
    doneInScan: assert property (
        @(posedge clk) disable iff (!res)
        scanDone |-> ((phase == scanA) || (phase == scanB))
    )
        else $error("sifhTop: scanDone outside a scan phase");

endmodule

/* sifhTb.sv */
module sifhTb;

    import sifhGeomPkg::*;

    logic  clk;
    logic  res;
    stampT stamp;
    logic  stampValid;
    logic  tdcReady;
    logic  resultValid;
    binT   coarseBin;
    binT   fineBin;
    countT fineCount;

    string names[$];
    int    expCoarse[$];
    int    expFine[$];
    int    expCount[$];
    stampT stampQ[$]; // coarse frame then fine frame, per test

    int   numTests;
    int   passCnt;
    int   failCnt;
    logic loaded;    // test table ready, watchdog may start
    logic fileError;

    sifhTop sifhTop_i (
        .clk         (clk),
        .res         (res),
        .stamp       (stamp),
        .stampValid  (stampValid),
        .tdcReady    (tdcReady),
        .resultValid (resultValid),
        .coarseBin   (coarseBin),
        .fineBin     (fineBin),
        .fineCount   (fineCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic readTests();
        int fd;
        int code;
        int i;
        logic [8*256-1:0] lineBuf;
        logic [8*32-1:0]  nameBuf;
        logic [31:0]      c;
        logic [31:0]      f;
        logic [31:0]      n;
        logic [31:0]      v;
        fd = $fopen("sifhTests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sifhTests.txt");
            fileError = 1'b1;
            return;
        end
        while ($fgets(lineBuf, fd) != 0) begin
            // comment and empty lines do not parse as a header
            code = $sscanf(lineBuf, "%s %h %h %h", nameBuf, c, f, n);
            if (code == 4) begin
                names.push_back(string'(nameBuf));
                expCoarse.push_back(int'(c));
                expFine.push_back(int'(f));
                expCount.push_back(int'(n));
                for (i = 0; i < 2 * stampsPerFrame; i++) begin
                    if ($fscanf(fd, "%h", v) != 1) begin
                        $display("test %s in sifhTests.txt has too few stamps",
                                 string'(nameBuf));
                        fileError = 1'b1;
                        v = '0;
                    end
                    stampQ.push_back(stampT'(v));
                end
            end
        end
        $fclose(fd);
    endtask

    // one strobe, only while the DUT is ready
    task automatic sendStamp(input stampT value);
        int gap;
        gap = $urandom % 5;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        while (!tdcReady) begin
            @(posedge clk);
            #1;
        end
        stamp = value;
        stampValid = 1'b1;
        @(posedge clk); // taken on this edge
        #1;
        stampValid = 1'b0;
    endtask

    task automatic checkField(input string testName, input string field,
                              input int expVal, input int actVal, inout int errs);
        if (expVal != actVal) begin
            $display("MISMATCH %s %s expected %0d actual %0d",
                     testName, field, expVal, actVal);
            errs++;
        end
    endtask

    task automatic runTest(input int t);
        int errs;
        int base;
        int i;
        errs = 0;
        base = t * 2 * stampsPerFrame;
        for (i = 0; i < 2 * stampsPerFrame; i++) begin
            sendStamp(stampQ[base + i]);
        end
        while (!resultValid) begin
            @(posedge clk);
            #1;
        end
        checkField(names[t], "coarseBin", expCoarse[t], int'(coarseBin), errs);
        checkField(names[t], "fineBin", expFine[t], int'(fineBin), errs);
        checkField(names[t], "fineCount", expCount[t], int'(fineCount), errs);
        @(posedge clk);
        #1;
        if (resultValid) begin
            $display("%s: resultValid stayed high for more than one cycle", names[t]);
            errs++;
        end
        if (errs == 0) begin
            $display("PASS %s", names[t]);
            passCnt++;
        end else begin
            failCnt++;
        end
    endtask

    initial begin
        res = 1'b0;
        stamp = '0;
        stampValid = 1'b0;
        passCnt = 0;
        failCnt = 0;
        loaded = 1'b0;
        fileError = 1'b0;
        void'($urandom(58726));
        readTests();
        numTests = names.size();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        res = 1'b1;
        // no reset between tests, so each pass relies on the clear phases
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("%0d tests passed, %0d tests failed", passCnt, failCnt);
        if ((failCnt == 0) && (numTests > 0) && !fileError) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // two frames of worst-case stamp spacing plus clear and scan time per test
    initial begin
        wait (loaded);
        repeat (numTests * (2 * stampsPerFrame * 8 + 200) + 10) @(posedge clk);
        $display("watchdog: the tests did not finish in time, run stopped");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
sifhGeomPkg.sv
sifhCtrlPkg.sv
histRam.sv
hisBuilder.sv
peakScanner.sv
sifhTop.sv
sifhTb.sv

/* sifhTests.txt */
# test name, expected coarseBin, fineBin and fineCount, all in hex
# then one line of 64 coarse-pass stamps and one line of 64 fine-pass stamps
coarseFine 0a 07 20
500 501 502 503 51C 520 57F 540 500 501 502 503 51C 520 57F 540 500 501 502 503 51C 520 57F 540 500 501 502 503 51C 520 57F 540 500 501 502 503 51C 520 57F 540 200 2FF 123 ABC 0FF 700 7FF FFF 200 2FF 123 ABC 0FF 700 7FF FFF 200 2FF 123 ABC 0FF 700 7FF FFF
51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF 51C 51D 51E 51F 50C 50D 200 FFF
windowFilter 03 0c 10
180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF 180 181 1A0 1FF 180 3FF 000 FFF
1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3 1B0 1B1 194 250 250 251 4D0 4D3
tieLow 14 09 18
A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F A00 A11 A22 A33 A44 A55 A66 A7F
A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C A58 A24 A59 A25 A5A A26 000 A7C
saturate 1f 12 3f
FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81 FC0 F80 FFF 001 FC0 FC0 F90 F81
FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8 FC8
emptyWindow 00 00 00
000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400 000 010 07F 040 001 002 800 400
080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123 080 100 FFF 7A4 080 555 0FF 123
backToBack 02 1f 18
300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120 300 37F 310 320 100 17F 110 120
17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E 17C 17D 17E 100 300 37C 37D 37E
